// File: source/peak_pkg.sv
////////////////////
// shared sizes and types for the stream peak detector
// channel count, sample and magnitude formats, burst length
////////////////////

package peak_pkg;

  ////////////////////
  // sizes
  ////////////////////

  // antenna channels per frame
  localparam int NUM_CHANNELS = 4;
  // signed sample width
  localparam int SAMPLE_WIDTH = 16;
  // frames per burst, also the boxcar window, power of two only
  localparam int BURST_LENGTH = 16;
  // centres the compared magnitude inside the window
  localparam int HALF_BURST = BURST_LENGTH / 2;
  // burst counter width and averaging divide shift
  localparam int COUNT_WIDTH = $clog2(BURST_LENGTH);
  // threshold is 8x the average
  localparam int THRESH_SHIFT = 3;

  ////////////////////
  // types
  ////////////////////

  // one signed sample
  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
  // one sample per channel
  typedef sample_t [NUM_CHANNELS-1:0] frame_t;
  // unsigned magnitude, holds |most negative| too
  typedef logic [SAMPLE_WIDTH-1:0] mag_t;
  typedef mag_t [NUM_CHANNELS-1:0] mag_frame_t;
  // running sum of BURST_LENGTH magnitudes
  typedef logic [SAMPLE_WIDTH+COUNT_WIDTH-1:0] sum_t;
  // one flag per channel
  typedef logic [NUM_CHANNELS-1:0] mask_t;

endpackage

// File: source/delay_line.sv
////////////////////
// enabled shift register with a generic entry type
////////////////////

module delay_line #(
  // entry type, sample frames or magnitudes
  parameter type T = logic,
  // number of register stages
  parameter int DEPTH = 2
) (
  input  logic clk,
  input  logic reset,
  // advance the chain one step
  input  logic shift,
  input  T     din,
  // oldest entry
  output T     dout
);

  // stage 0 is the newest entry
  T stages [DEPTH];

  ////////////////////
  // register chain
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      // whole chain reads as zero history
      for (int i = 0; i < DEPTH; i++) begin
        stages[i] <= '0;
      end
    end else if (shift) begin
      stages[0] <= din;
      // everything moves one place towards the output
      for (int i = 1; i < DEPTH; i++) begin
        stages[i] <= stages[i-1];
      end
    end
  end

  // last stage leaves on the next shift
  // so dout is the entry DEPTH shifts old
  assign dout = stages[DEPTH-1];

endmodule

// File: source/boxcar_avg.sv
////////////////////
// running boxcar average of one channel magnitude
////////////////////

module boxcar_avg (
  input  logic           clk,
  input  logic           reset,
  // one accepted sample
  input  logic           shift,
  input  peak_pkg::mag_t mag,
  // mean over the window including mag
  output peak_pkg::mag_t avg
);

  // magnitude falling out of the window
  peak_pkg::mag_t mag_old;
  // registered sum of the last BURST_LENGTH magnitudes
  peak_pkg::sum_t sum;
  // sum once the current sample is accepted
  peak_pkg::sum_t sum_next;

  ////////////////////
  // window history
  ////////////////////

  // dout is the sample BURST_LENGTH accepts back
  delay_line #(
    .T     (peak_pkg::mag_t),
    .DEPTH (peak_pkg::BURST_LENGTH)
  ) u_history (
    .clk   (clk),
    .reset (reset),
    .shift (shift),
    .din   (mag),
    .dout  (mag_old)
  );

  ////////////////////
  // running sum
  ////////////////////

  // add the newcomer, drop the leaver
  // sum never goes below mag_old, no underflow
  assign sum_next = sum + peak_pkg::sum_t'(mag) - peak_pkg::sum_t'(mag_old);

  always_ff @(posedge clk) begin
    if (reset) begin
      sum <= '0;
    end else if (shift) begin
      sum <= sum_next;
    end
  end

  // divide by BURST_LENGTH
  // uses sum_next so the current frame counts in the mean
  assign avg = peak_pkg::mag_t'(sum_next >> peak_pkg::COUNT_WIDTH);

endmodule

// File: source/peak_finder.sv
////////////////////
// per-channel magnitude, boxcar mean and threshold test
// registered peak mask with a valid pulse
////////////////////

module peak_finder (
  input  logic             clk,
  input  logic             reset,
  // frame strobe, one cycle per accepted frame
  input  logic             valid,
  input  peak_pkg::frame_t data,
  // high in the cycle after an accepted frame
  output logic             peak_valid,
  // decisions for that frame
  output peak_pkg::mask_t  peak_mask
);

  // magnitudes of the incoming frame
  peak_pkg::mag_frame_t mag;
  // magnitudes HALF_BURST frames back
  peak_pkg::mag_frame_t mag_mid;
  // boxcar means, current frame included
  peak_pkg::mag_frame_t avg;
  // comparison result before the register
  peak_pkg::mask_t      decision;

  ////////////////////
  // per-channel path
  ////////////////////

  for (genvar c = 0; c < peak_pkg::NUM_CHANNELS; c++) begin : g_chan
    // avg+1 shifted needs THRESH_SHIFT+1 extra bits
    logic [peak_pkg::SAMPLE_WIDTH+peak_pkg::THRESH_SHIFT:0] thresh;

    // abs value, -32768 maps to 32768 unsigned
    assign mag[c] = peak_pkg::mag_t'(data[c][peak_pkg::SAMPLE_WIDTH-1] ?
                                     -data[c] : data[c]);

    boxcar_avg u_avg (
      .clk   (clk),
      .reset (reset),
      .shift (valid),
      .mag   (mag[c]),
      .avg   (avg[c])
    );

    // +1 keeps a silent channel from tripping on tiny samples
    assign thresh = ({{(peak_pkg::THRESH_SHIFT + 1){1'b0}}, avg[c]} + 1'b1)
                    << peak_pkg::THRESH_SHIFT;

    // strictly above the scaled mean
    assign decision[c] = mag_mid[c] > thresh;
  end

  ////////////////////
  // centre delay
  ////////////////////

  // whole magnitude frame delayed to the middle of the window
  // dout before the shift is frame k-HALF_BURST
  delay_line #(
    .T     (peak_pkg::mag_frame_t),
    .DEPTH (peak_pkg::HALF_BURST)
  ) u_centre (
    .clk   (clk),
    .reset (reset),
    .shift (valid),
    .din   (mag),
    .dout  (mag_mid)
  );

  ////////////////////
  // output register
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      peak_valid <= 1'b0;
      peak_mask  <= '0;
    end else begin
      peak_valid <= valid;
      // mask only moves with an accepted frame
      if (valid) begin
        peak_mask <= decision;
      end
    end
  end

endmodule

// File: source/burst_control.sv
////////////////////
// trigger edge detect and burst readout control
// window shift and fill, output valid, last and mask
////////////////////

module burst_control (
  input  logic            clk,
  input  logic            reset,
  // decision from the peak finder
  input  logic            peak_valid,
  input  peak_pkg::mask_t peak_mask,
  // input frame strobe
  input  logic            valid,
  // capture window control
  output logic            window_shift,
  output logic            window_fill,
  // output stream
  output logic            m_valid,
  input  logic            m_ready,
  output logic            m_last,
  output peak_pkg::mask_t m_mask
);

  // mask of the previous decision, for the edge rule
  peak_pkg::mask_t                   prev_mask;
  // burst being read out
  logic                              busy;
  // words already sent in this burst
  logic [peak_pkg::COUNT_WIDTH-1:0]  count;
  // channels that peaked, held for the burst
  peak_pkg::mask_t                   cap_mask;
  logic                              trigger;
  logic                              transfer;

  ////////////////////
  // trigger
  ////////////////////

  // rising edge of any-peak, only when idle
  assign trigger = peak_valid & (|peak_mask) & ~(|prev_mask) & ~busy;

  assign transfer = m_valid & m_ready;

  ////////////////////
  // control state
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      prev_mask <= '0;
      busy      <= 1'b0;
      count     <= '0;
    end else begin
      // updated by every decision, busy or not
      if (peak_valid) begin
        prev_mask <= peak_mask;
      end
      if (trigger) begin
        busy  <= 1'b1;
        count <= '0;
      end else if (transfer) begin
        count <= count + 1'b1;
        // idle from the cycle after the last word
        if (m_last) begin
          busy <= 1'b0;
        end
      end
    end
  end

  // mask held for the whole burst
  always_ff @(posedge clk) begin
    if (trigger) begin
      cap_mask <= peak_mask;
    end
  end

  ////////////////////
  // window control
  ////////////////////

  // idle: write each frame, except one accepted in the trigger cycle
  // busy: shift out one word per transfer
  assign window_shift = busy ? transfer : (valid & ~trigger);

  // zeros enter behind the readout
  assign window_fill = ~busy;

  ////////////////////
  // output stream
  ////////////////////

  assign m_valid = busy;

  // counter all ones is word BURST_LENGTH, power of two length
  assign m_last = busy & (&count);

  assign m_mask = cap_mask;

endmodule

// File: source/peak_detector_top.sv
////////////////////
// stream peak detector top level
// peak finder, capture window and burst controller
////////////////////

module peak_detector_top (
  input  logic             clk,
  input  logic             reset,
  // input frames, no back-pressure
  input  logic             valid,
  input  peak_pkg::frame_t data,
  // burst output stream
  output logic             m_valid,
  input  logic             m_ready,
  output peak_pkg::frame_t m_data,
  output logic             m_last,
  output peak_pkg::mask_t  m_mask
);

  // finder to controller
  logic             peak_valid;
  peak_pkg::mask_t  peak_mask;
  // controller to window
  logic             window_shift;
  logic             window_fill;
  // frame or zero into the window
  peak_pkg::frame_t window_din;

  ////////////////////
  // peak detection
  ////////////////////

  peak_finder u_finder (
    .clk        (clk),
    .reset      (reset),
    .valid      (valid),
    .data       (data),
    .peak_valid (peak_valid),
    .peak_mask  (peak_mask)
  );

  ////////////////////
  // burst control
  ////////////////////

  burst_control u_control (
    .clk          (clk),
    .reset        (reset),
    .peak_valid   (peak_valid),
    .peak_mask    (peak_mask),
    .valid        (valid),
    .window_shift (window_shift),
    .window_fill  (window_fill),
    .m_valid      (m_valid),
    .m_ready      (m_ready),
    .m_last       (m_last),
    .m_mask       (m_mask)
  );

  ////////////////////
  // capture window
  ////////////////////

  // zero fill during readout
  assign window_din = window_fill ? data : '0;

  // oldest frame sits at the output
  delay_line #(
    .T     (peak_pkg::frame_t),
    .DEPTH (peak_pkg::BURST_LENGTH)
  ) u_window (
    .clk   (clk),
    .reset (reset),
    .shift (window_shift),
    .din   (window_din),
    .dout  (m_data)
  );

endmodule

// File: verif/peak_detector_props.sv
////////////////////
// bound assertions on the burst output stream
////////////////////

module peak_detector_props (
  input logic             clk,
  input logic             reset,
  input logic             m_valid,
  input logic             m_ready,
  input peak_pkg::frame_t m_data,
  input logic             m_last,
  input peak_pkg::mask_t  m_mask
);

  // read by the testbench at the end of the run
  int unsigned failures = 0;

  // no burst comes out of a reset
  valid_low_in_reset: assert property (@(posedge clk) reset |=> !m_valid)
    else begin
      $error("m_valid high after a reset cycle");
      failures++;
    end

  // stalled word waits unchanged
  hold_under_stall: assert property (@(posedge clk) disable iff (reset)
    (m_valid && !m_ready) |=> (m_valid && $stable(m_data) && $stable(m_mask)))
    else begin
      $error("burst word changed under a stall");
      failures++;
    end

  // a burst always names at least one channel
  mask_nonzero: assert property (@(posedge clk) disable iff (reset)
    m_valid |-> (m_mask != '0))
    else begin
      $error("empty mask during a burst");
      failures++;
    end

  // burst closes right after its last word
  last_ends_burst: assert property (@(posedge clk) disable iff (reset)
    (m_valid && m_ready && m_last) |=> !m_valid)
    else begin
      $error("m_valid still high after the last word");
      failures++;
    end

endmodule

bind peak_detector_top peak_detector_props u_props (
  .clk     (clk),
  .reset   (reset),
  .m_valid (m_valid),
  .m_ready (m_ready),
  .m_data  (m_data),
  .m_last  (m_last),
  .m_mask  (m_mask)
);

// File: verif/peak_detector_tb.sv
////////////////////
// testbench for the stream peak detector
// stimulus phases, cycle model, output compare and timeout
////////////////////

module peak_detector_tb;

  // run length in frames over all phases
  localparam int FRAME_COUNT = 320;
  localparam int MAX_GAP     = 3;
  localparam int BURST_COUNT = 7;
  // longest run of m_ready low
  localparam int MAX_STALL   = 8;
  localparam int TIMEOUT_CYCLES =
    FRAME_COUNT * (MAX_GAP + 1) + 16 * 8 * BURST_COUNT * MAX_STALL + 1000;

  // index 0 is the newest magnitude
  typedef int unsigned hist_t [peak_pkg::BURST_LENGTH];

  logic             clk;
  logic             reset;
  logic             valid;
  peak_pkg::frame_t data;
  logic             m_valid;
  logic             m_ready;
  peak_pkg::frame_t m_data;
  logic             m_last;
  peak_pkg::mask_t  m_mask;

  int gap_max;
  int ready_pct;
  int bursts_done;

  ////////////////////
  // model state
  ////////////////////

  hist_t            hist [peak_pkg::NUM_CHANNELS];
  // capture window, oldest first
  peak_pkg::frame_t window [$];
  logic             exp_pv;
  peak_pkg::mask_t  exp_pmask;
  peak_pkg::mask_t  exp_prev;
  logic             exp_busy;
  int               exp_sent;
  peak_pkg::frame_t exp_frames [$];
  peak_pkg::mask_t  exp_masks [$];
  logic             exp_lasts [$];

  peak_detector_top dut (
    .clk     (clk),
    .reset   (reset),
    .valid   (valid),
    .data    (data),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data),
    .m_last  (m_last),
    .m_mask  (m_mask)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////
  // reference
  ////////////////////

  function automatic int unsigned magnitude(input peak_pkg::sample_t s);
    int value;
    value = s;
    if (value < 0) value = -value;
    return int'(value);
  endfunction

  // mean of the last BURST_LENGTH magnitudes with the current one included
  function automatic int unsigned window_average(input hist_t h);
    int unsigned total;
    total = 0;
    for (int i = 0; i < peak_pkg::BURST_LENGTH; i++) total += h[i];
    return total / peak_pkg::BURST_LENGTH;
  endfunction

  // centre magnitude against 8 x (mean + 1)
  function automatic bit is_peak(input hist_t h);
    return h[peak_pkg::HALF_BURST] > (window_average(h) + 1) * (1 << peak_pkg::THRESH_SHIFT);
  endfunction

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("Errors found");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_frame(input peak_pkg::frame_t got, input peak_pkg::frame_t exp);
    if (got !== exp)
      report_failure($sformatf("ERROR %0t: m_data %h, expected %h", $time, got, exp));
  endtask

  task automatic check_mask(input peak_pkg::mask_t got, input peak_pkg::mask_t exp);
    if (got !== exp)
      report_failure($sformatf("ERROR %0t: m_mask %b, expected %b", $time, got, exp));
  endtask

  task automatic check_last(input logic got, input logic exp);
    if (got !== exp)
      report_failure($sformatf("ERROR %0t: m_last %b, expected %b", $time, got, exp));
  endtask

  task automatic check_valid(input logic got, input logic exp);
    if (got !== exp)
      report_failure($sformatf("ERROR %0t: m_valid %b, expected %b", $time, got, exp));
  endtask

  task automatic reset_model();
    window.delete();
    repeat (peak_pkg::BURST_LENGTH) window.push_back('0);
    for (int c = 0; c < peak_pkg::NUM_CHANNELS; c++) begin
      for (int i = 0; i < peak_pkg::BURST_LENGTH; i++) hist[c][i] = 0;
    end
    exp_pv    = 1'b0;
    exp_pmask = '0;
    exp_prev  = '0;
    exp_busy  = 1'b0;
    exp_sent  = 0;
  endtask

  // one clock edge of the output side
  task automatic advance_model();
    bit              trig;
    peak_pkg::mask_t decision;
    trig = exp_pv && (exp_pmask != '0) && (exp_prev == '0) && !exp_busy;
    if (!exp_busy && valid && !trig) begin
      window.push_back(data);
      void'(window.pop_front());
    end
    if (exp_pv) exp_prev = exp_pmask;
    if (trig) begin
      // burst frozen here and readout leaves zeros behind
      for (int i = 0; i < peak_pkg::BURST_LENGTH; i++) begin
        exp_frames.push_back(window[i]);
        exp_masks.push_back(exp_pmask);
        exp_lasts.push_back(i == peak_pkg::BURST_LENGTH - 1);
        window[i] = '0;
      end
      exp_busy = 1'b1;
      exp_sent = 0;
    end else if (exp_busy && m_ready) begin
      exp_sent++;
      if (exp_sent == peak_pkg::BURST_LENGTH) exp_busy = 1'b0;
    end
    if (valid) begin
      decision = '0;
      for (int c = 0; c < peak_pkg::NUM_CHANNELS; c++) begin
        for (int i = peak_pkg::BURST_LENGTH - 1; i > 0; i--) hist[c][i] = hist[c][i-1];
        hist[c][0] = magnitude(data[c]);
        decision[c] = is_peak(hist[c]);
      end
      exp_pmask = decision;
    end
    exp_pv = valid;
  endtask

  ////////////////////
  // compare
  ////////////////////

  // inputs change on the falling edge so both sides are settled here
  always @(posedge clk) begin
    if (reset) begin
      reset_model();
    end else begin
      check_valid(m_valid, exp_busy);
      if (m_valid && m_ready) begin
        if (exp_frames.size() == 0) begin
          report_failure($sformatf("ERROR %0t: transfer with no burst expected", $time));
        end else begin
          check_frame(m_data, exp_frames.pop_front());
          check_mask(m_mask, exp_masks.pop_front());
          check_last(m_last, exp_lasts.pop_front());
          if (m_last) bursts_done++;
        end
      end
      advance_model();
    end
  end

  initial begin : timeout_watch
    int cycles;
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles >= TIMEOUT_CYCLES)
        report_failure($sformatf("Timeout: run not finished after %0d cycles", cycles));
    end
  end

  // random back-pressure with stall runs capped at MAX_STALL
  initial begin : ready_drive
    int stall_run;
    m_ready = 1'b1;
    stall_run = 0;
    forever begin
      @(negedge clk);
      if (stall_run >= MAX_STALL || int'($urandom_range(99, 0)) < ready_pct) begin
        m_ready = 1'b1;
        stall_run = 0;
      end else begin
        m_ready = 1'b0;
        stall_run++;
      end
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  function automatic peak_pkg::frame_t noise_frame();
    peak_pkg::frame_t f;
    // magnitude under 8 never beats the smallest threshold
    for (int c = 0; c < peak_pkg::NUM_CHANNELS; c++)
      f[c] = peak_pkg::sample_t'(int'($urandom_range(14, 0)) - 7);
    return f;
  endfunction

  function automatic peak_pkg::frame_t spike(input peak_pkg::frame_t base, input int ch,
                                             input peak_pkg::sample_t value);
    base[ch] = value;
    return base;
  endfunction

  task automatic send_frame(input peak_pkg::frame_t frame);
    int gap;
    gap = (gap_max > 0) ? int'($urandom_range(gap_max, 0)) : 0;
    repeat (gap) begin
      @(negedge clk);
      valid = 1'b0;
    end
    @(negedge clk);
    valid = 1'b1;
    data  = frame;
  endtask

  task automatic send_noise(input int count);
    repeat (count) send_frame(noise_frame());
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    valid = 1'b0;
  endtask

  // through the trigger and the whole readout with frames or silence
  task automatic ride_out_burst(input bit keep_sending);
    repeat (2) if (keep_sending) send_noise(1); else idle_cycle();
    while (exp_busy) if (keep_sending) send_noise(1); else idle_cycle();
  endtask

  task automatic drain();
    repeat (2) idle_cycle();
    while (exp_busy || exp_frames.size() != 0) idle_cycle();
  endtask

  task automatic expect_bursts(input int total, input string phase);
    if (bursts_done != total)
      report_failure($sformatf("ERROR %0t: %s gave %0d bursts in total, expected %0d",
                               $time, phase, bursts_done, total));
  endtask

  initial begin
    void'($urandom(32'hc132));
    reset = 1'b1;
    valid = 1'b0;
    data = '0;
    gap_max = 0;
    ready_pct = 100;
    bursts_done = 0;
    repeat (10) @(negedge clk);
    reset = 1'b0;

    // quiet noise
    send_noise(40);
    drain();
    expect_bursts(0, "quiet noise");

    // one spike on channel 1
    send_frame(spike(noise_frame(), 1, peak_pkg::sample_t'(20000)));
    send_noise(20);
    drain();
    expect_bursts(1, "single spike");

    // three channels at once with one at the most negative value
    send_frame(spike(spike(spike(noise_frame(), 0, peak_pkg::sample_t'(16'h8000)),
                           2, peak_pkg::sample_t'(30000)), 3, peak_pkg::sample_t'(-15000)));
    send_noise(20);
    drain();
    expect_bursts(2, "multi-channel spike");

    // gaps in valid and random back-pressure
    gap_max = MAX_GAP;
    ready_pct = 40;
    send_noise(20);
    send_frame(spike(noise_frame(), 2, peak_pkg::sample_t'(25000)));
    send_noise(8);
    // first burst drains before the next spike
    ride_out_burst(1'b1);
    send_noise(12);
    send_frame(spike(noise_frame(), 3, peak_pkg::sample_t'(-20000)));
    send_noise(20);
    drain();
    expect_bursts(4, "back-pressure");

    // second decision waits out the burst and the edge rule blocks it
    gap_max = 0;
    ready_pct = 100;
    send_noise(20);
    send_frame(spike(noise_frame(), 0, peak_pkg::sample_t'(20000)));
    send_frame(spike(noise_frame(), 1, peak_pkg::sample_t'(20000)));
    send_noise(7);
    ride_out_burst(1'b0);
    send_noise(20);
    drain();
    expect_bursts(5, "long peak");

    // channel 3 peaks mid-burst and then a new burst with zero entries
    ready_pct = 30;
    send_noise(20);
    send_frame(spike(noise_frame(), 2, peak_pkg::sample_t'(20000)));
    send_noise(4);
    send_frame(spike(noise_frame(), 3, peak_pkg::sample_t'(20000)));
    send_noise(3);
    ride_out_burst(1'b1);
    send_frame(spike(noise_frame(), 1, peak_pkg::sample_t'(20000)));
    send_noise(12);
    drain();
    expect_bursts(BURST_COUNT, "peak during burst");

    if (dut.u_props.failures != 0 || exp_frames.size() != 0) begin
      report_failure($sformatf("ERROR %0t: %0d assertion failures, %0d words never sent",
                               $time, dut.u_props.failures, exp_frames.size()));
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

// File: files.f
source/peak_pkg.sv
source/delay_line.sv
source/boxcar_avg.sv
source/peak_finder.sv
source/burst_control.sv
source/peak_detector_top.sv
verif/peak_detector_props.sv
verif/peak_detector_tb.sv

// File: Makefile
# Verilator build and run for the stream peak detector

VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal -j 0
TOP       = peak_detector_tb
FILE_LIST = files.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Errors found
PASS_MSG  = No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, report pass or fail"
	@echo "  clean  remove the build folder and the log"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "TEST FAILED, run ended early"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
